// ==== design/cpu_pkg.sv ====
package cpu_pkg;

    localparam int WORD_W = 16;

    // ##########################################################
    // Instruction encodings
    // ##########################################################

    typedef enum logic [3:0] {
        OP_BNE   = 4'd0,
        OP_BEQ   = 4'd1,
        OP_BGZ   = 4'd2,
        OP_BLZ   = 4'd3,
        OP_ADI   = 4'd4,
        OP_ORI   = 4'd5,
        OP_LHI   = 4'd6,
        OP_LWD   = 4'd7,
        OP_SWD   = 4'd8,
        OP_JMP   = 4'd9,
        OP_JAL   = 4'd10,
        OP_RTYPE = 4'd15
    } opcode_e;

    typedef enum logic [5:0] {
        FN_ADD = 6'd0,
        FN_SUB = 6'd1,
        FN_AND = 6'd2,
        FN_ORR = 6'd3,
        FN_NOT = 6'd4,
        FN_TCP = 6'd5,
        FN_SHL = 6'd6,
        FN_SHR = 6'd7,
        FN_JPR = 6'd25,
        FN_JRL = 6'd26,
        FN_WWD = 6'd28,
        FN_HLT = 6'd29
    } func_e;

    typedef struct packed {
        opcode_e     opcode;
        logic [1:0]  rs;
        logic [1:0]  rt;
        logic [1:0]  rd;
        func_e       func;
    } r_form_t;

    typedef struct packed {
        opcode_e     opcode;
        logic [1:0]  rs;
        logic [1:0]  rt;
        logic [7:0]  imm;
    } i_form_t;

    typedef struct packed {
        opcode_e     opcode;
        logic [11:0] target;
    } j_form_t;

    // Same 16 bits seen as register, immediate or jump form
    typedef union packed {
        r_form_t r;
        i_form_t i;
        j_form_t j;
    } instr_t;

    // ##########################################################
    // Datapath controls
    // ##########################################################

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_NOT,
        ALU_TCP, ALU_SHL, ALU_SHR, ALU_PASS_B
    } alu_op_e;

    typedef enum logic [1:0] {WB_ALU, WB_MEM, WB_PC1} wb_sel_e;

    typedef enum logic [1:0] {PC_SEQ, PC_BRANCH, PC_JUMP, PC_REG} pc_sel_e;

    typedef enum logic [1:0] {EXT_SIGN, EXT_ZERO_HIGH, EXT_ZERO_LOW, EXT_TARGET} ext_kind_e;

endpackage

// ==== design/imm_extender.sv ====
`timescale 1ns/1ps

module imm_extender (
    input  logic [cpu_pkg::WORD_W-1:0] pc,
    input  cpu_pkg::opcode_e           opcode,
    input  logic [7:0]                 imm,
    input  logic [11:0]                target,
    output logic [cpu_pkg::WORD_W-1:0] ext_value
);
    import cpu_pkg::*;

    ext_kind_e         mode;
    logic              mode_known;
    logic [WORD_W-1:0] widened;

    always_comb begin
        mode       = EXT_SIGN;
        mode_known = 1'b1;
        case (opcode)
            OP_ADI, OP_LWD, OP_SWD,
            OP_BNE, OP_BEQ, OP_BGZ, OP_BLZ: mode = EXT_SIGN;
            OP_ORI:                         mode = EXT_ZERO_HIGH;
            OP_LHI:                         mode = EXT_ZERO_LOW;
            OP_JMP, OP_JAL:                 mode = EXT_TARGET;
            default:                        mode_known = 1'b0;
        endcase
    end

    always_comb begin
        case (mode)
            EXT_SIGN:      widened = {{8{imm[7]}}, imm};
            EXT_ZERO_HIGH: widened = {8'h00, imm};
            EXT_ZERO_LOW:  widened = {imm, 8'h00};
            // Jumps stay inside the current 4K page
            EXT_TARGET:    widened = {pc[15:12], target};
            default:       widened = '0;
        endcase
    end

    assign ext_value = mode_known ? widened : '0;

endmodule

// ==== design/control_decoder.sv ====
`timescale 1ns/1ps

module control_decoder (
    input  cpu_pkg::instr_t   instr,
    output logic              reg_we,
    output logic [1:0]        rd_idx,
    output cpu_pkg::alu_op_e  alu_op,
    output logic              alu_src_imm,
    output cpu_pkg::ext_kind_e ext_kind,
    output cpu_pkg::wb_sel_e  wb_sel,
    output cpu_pkg::pc_sel_e  pc_sel_base,
    output logic [1:0]        branch_kind,
    output logic              is_branch,
    output logic              mem_we,
    output logic              out_strobe,
    output logic              halt
);
    import cpu_pkg::*;

    always_comb begin
        reg_we      = 1'b0;
        rd_idx      = instr.i.rt;
        alu_op      = ALU_ADD;
        alu_src_imm = 1'b0;
        ext_kind    = EXT_SIGN;
        wb_sel      = WB_ALU;
        pc_sel_base = PC_SEQ;
        branch_kind = instr.i.opcode[1:0];
        is_branch   = 1'b0;
        mem_we      = 1'b0;
        out_strobe  = 1'b0;
        halt        = 1'b0;

        case (instr.i.opcode)
            OP_ADI: begin
                reg_we      = 1'b1;
                alu_src_imm = 1'b1;
            end
            OP_ORI: begin
                reg_we      = 1'b1;
                alu_op      = ALU_OR;
                alu_src_imm = 1'b1;
                ext_kind    = EXT_ZERO_HIGH;
            end
            OP_LHI: begin
                reg_we      = 1'b1;
                alu_op      = ALU_PASS_B;
                alu_src_imm = 1'b1;
                ext_kind    = EXT_ZERO_LOW;
            end
            OP_LWD: begin
                reg_we      = 1'b1;
                alu_src_imm = 1'b1;
                wb_sel      = WB_MEM;
            end
            OP_SWD: begin
                mem_we      = 1'b1;
                alu_src_imm = 1'b1;
            end
            // Branch kind comes straight from the low opcode bits
            OP_BNE, OP_BEQ, OP_BGZ, OP_BLZ: begin
                alu_op      = ALU_SUB;
                is_branch   = 1'b1;
                pc_sel_base = PC_BRANCH;
            end
            OP_JMP, OP_JAL: begin
                ext_kind    = EXT_TARGET;
                pc_sel_base = PC_JUMP;
                if (instr.i.opcode == OP_JAL) begin
                    reg_we = 1'b1;
                    rd_idx = 2'd2;
                    wb_sel = WB_PC1;
                end
            end
            OP_RTYPE: begin
                rd_idx = instr.r.rd;
                case (instr.r.func)
                    FN_ADD: begin
                        reg_we = 1'b1;
                        alu_op = ALU_ADD;
                    end
                    FN_SUB: begin
                        reg_we = 1'b1;
                        alu_op = ALU_SUB;
                    end
                    FN_AND: begin
                        reg_we = 1'b1;
                        alu_op = ALU_AND;
                    end
                    FN_ORR: begin
                        reg_we = 1'b1;
                        alu_op = ALU_OR;
                    end
                    FN_NOT: begin
                        reg_we = 1'b1;
                        alu_op = ALU_NOT;
                    end
                    FN_TCP: begin
                        reg_we = 1'b1;
                        alu_op = ALU_TCP;
                    end
                    FN_SHL: begin
                        reg_we = 1'b1;
                        alu_op = ALU_SHL;
                    end
                    FN_SHR: begin
                        reg_we = 1'b1;
                        alu_op = ALU_SHR;
                    end
                    FN_WWD: out_strobe = 1'b1;
                    FN_JPR: pc_sel_base = PC_REG;
                    FN_JRL: begin
                        pc_sel_base = PC_REG;
                        reg_we      = 1'b1;
                        rd_idx      = 2'd2;
                        wb_sel      = WB_PC1;
                    end
                    FN_HLT: halt = 1'b1;
                    default: ;
                endcase
            end
            default: ;
        endcase
    end

    // Checked each time a new instruction word replaces the previous one
    a_unknown_func_no_write: assert property (@(instr)
        (instr.r.opcode == OP_RTYPE &&
         !(instr.r.func inside {FN_ADD, FN_SUB, FN_AND, FN_ORR, FN_NOT, FN_TCP,
                                FN_SHL, FN_SHR, FN_WWD, FN_JPR, FN_JRL, FN_HLT}))
        |-> !reg_we);

endmodule

// ==== design/register_file.sv ====
`timescale 1ns/1ps

module register_file (
    input  logic                       clk,
    input  logic                       arst_n,
    input  logic [1:0]                 rs_idx,
    input  logic [1:0]                 rt_idx,
    output logic [cpu_pkg::WORD_W-1:0] rs_val,
    output logic [cpu_pkg::WORD_W-1:0] rt_val,
    input  logic                       we,
    input  logic [1:0]                 wd_idx,
    input  logic [cpu_pkg::WORD_W-1:0] wd_val
);
    import cpu_pkg::*;

    logic [WORD_W-1:0] regs [4];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < 4; i++) begin
                regs[i] <= '0;
            end
        end else if (we) begin
            regs[wd_idx] <= wd_val;
        end
    end

    // Reads see the old value until the write edge has passed
    assign rs_val = regs[rs_idx];
    assign rt_val = regs[rt_idx];

endmodule

// ==== design/alu.sv ====
`timescale 1ns/1ps

module alu (
    input  logic [cpu_pkg::WORD_W-1:0] a,
    input  logic [cpu_pkg::WORD_W-1:0] b,
    input  cpu_pkg::alu_op_e           op,
    input  logic [1:0]                 branch_kind,
    output logic [cpu_pkg::WORD_W-1:0] result,
    output logic                       branch_taken
);
    import cpu_pkg::*;

    always_comb begin
        case (op)
            ALU_ADD:    result = a + b;
            ALU_SUB:    result = a - b;
            ALU_AND:    result = a & b;
            ALU_OR:     result = a | b;
            ALU_NOT:    result = ~a;
            ALU_TCP:    result = ~a + 16'd1;
            ALU_SHL:    result = {a[WORD_W-2:0], 1'b0};
            ALU_SHR:    result = {1'b0, a[WORD_W-1:1]};
            ALU_PASS_B: result = b;
            default:    result = '0;
        endcase
    end

    // ##########################################################
    // Branch conditions, indexed by the low opcode bits
    // ##########################################################

    always_comb begin
        case (branch_kind)
            2'd0:    branch_taken = (a != b);
            2'd1:    branch_taken = (a == b);
            2'd2:    branch_taken = ($signed(a) > 0);
            default: branch_taken = ($signed(a) < 0);
        endcase
    end

endmodule

// ==== design/cpu_core.sv ====
`timescale 1ns/1ps

module cpu_core #(
    parameter logic [cpu_pkg::WORD_W-1:0] RESET_PC = '0
) (
    input  logic                       clk,
    input  logic                       arst_n,
    input  logic [cpu_pkg::WORD_W-1:0] i_data,
    output logic [cpu_pkg::WORD_W-1:0] i_addr,
    output logic [cpu_pkg::WORD_W-1:0] d_addr,
    output logic [cpu_pkg::WORD_W-1:0] d_wdata,
    output logic                       d_we,
    input  logic [cpu_pkg::WORD_W-1:0] d_rdata,
    output logic                       out_valid,
    output logic [cpu_pkg::WORD_W-1:0] out_data,
    output logic                       halted
);
    import cpu_pkg::*;

    instr_t            instr;
    logic [WORD_W-1:0] pc, pc_plus1, br_target, next_pc;
    logic              run, halt_q, active;

    logic              reg_we, alu_src_imm, is_branch, mem_we, out_strobe, halt;
    logic [1:0]        rd_idx, branch_kind;
    alu_op_e           alu_op;
    ext_kind_e         ext_kind;
    wb_sel_e           wb_sel;
    pc_sel_e           pc_sel_base, pc_sel;

    logic [WORD_W-1:0] ext_value, rs_val, rt_val, alu_b, alu_result, wb_val;
    logic              branch_taken;

    assign instr  = i_data;
    assign i_addr = pc;

    // The first cycle after reset release is idle while run comes up
    assign active = run & ~halt_q;

    control_decoder u_decoder (
        .instr       (instr),
        .reg_we      (reg_we),
        .rd_idx      (rd_idx),
        .alu_op      (alu_op),
        .alu_src_imm (alu_src_imm),
        .ext_kind    (ext_kind),
        .wb_sel      (wb_sel),
        .pc_sel_base (pc_sel_base),
        .branch_kind (branch_kind),
        .is_branch   (is_branch),
        .mem_we      (mem_we),
        .out_strobe  (out_strobe),
        .halt        (halt)
    );

    imm_extender u_extender (
        .pc        (pc),
        .opcode    (instr.i.opcode),
        .imm       (instr.i.imm),
        .target    (instr.j.target),
        .ext_value (ext_value)
    );

    register_file u_regs (
        .clk    (clk),
        .arst_n (arst_n),
        .rs_idx (instr.i.rs),
        .rt_idx (instr.i.rt),
        .rs_val (rs_val),
        .rt_val (rt_val),
        .we     (reg_we & active),
        .wd_idx (rd_idx),
        .wd_val (wb_val)
    );

    assign alu_b = alu_src_imm ? ext_value : rt_val;

    alu u_alu (
        .a            (rs_val),
        .b            (alu_b),
        .op           (alu_op),
        .branch_kind  (branch_kind),
        .result       (alu_result),
        .branch_taken (branch_taken)
    );

    // ##########################################################
    // Next PC and write-back
    // ##########################################################

    assign pc_plus1  = pc + 16'd1;
    assign br_target = pc_plus1 + ext_value;
    assign pc_sel    = (is_branch && !branch_taken) ? PC_SEQ : pc_sel_base;

    always_comb begin
        case (pc_sel)
            PC_BRANCH: next_pc = br_target;
            PC_JUMP:   next_pc = ext_value;
            PC_REG:    next_pc = rs_val;
            default:   next_pc = pc_plus1;
        endcase
        case (wb_sel)
            WB_MEM:  wb_val = d_rdata;
            WB_PC1:  wb_val = pc_plus1;
            default: wb_val = alu_result;
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pc     <= RESET_PC;
            run    <= 1'b0;
            halt_q <= 1'b0;
        end else begin
            run <= 1'b1;
            if (active) begin
                pc <= next_pc;
                if (halt) halt_q <= 1'b1;
            end
        end
    end

    assign d_addr    = alu_result;
    assign d_wdata   = rt_val;
    assign d_we      = mem_we & active;
    assign out_valid = out_strobe & active;
    assign out_data  = rs_val;
    assign halted    = halt_q;

    a_strobes_exclusive: assert property (@(posedge clk) disable iff (!arst_n)
        !(d_we && out_valid));

    a_halt_sticky: assert property (@(posedge clk) disable iff (!arst_n)
        halted |=> halted);

    // Decoder's extender mode must agree with the value the extender built
    a_ext_consistent: assert property (@(posedge clk) disable iff (!arst_n)
        (ext_kind == EXT_ZERO_HIGH |-> ext_value[15:8] == 8'h00) and
        (ext_kind == EXT_ZERO_LOW  |-> ext_value[7:0] == 8'h00) and
        (ext_kind == EXT_TARGET    |-> ext_value[15:12] == pc[15:12]));

endmodule

// ==== verif/cpu_ref_model.svh ====
`ifndef CPU_REF_MODEL_SVH
`define CPU_REF_MODEL_SVH

// Architectural state of the instruction-set model
logic [15:0] m_pc;
logic [15:0] m_regs [4];
logic [15:0] m_dmem [256];
logic        m_halted;

// Port activity expected while the current instruction executes
logic        exp_mem_access;
logic        exp_d_we;
logic [15:0] exp_d_addr;
logic [15:0] exp_d_wdata;
logic        exp_out_valid;
logic [15:0] exp_out_data;

function automatic logic [15:0] sign_extend(input logic [7:0] v);
    return {{8{v[7]}}, v};
endfunction

task automatic reset_model();
    m_pc     = RESET_PC;
    m_halted = 1'b0;
    for (int r = 0; r < 4; r++) begin
        m_regs[r] = '0;
    end
endtask

task automatic execute_instr(input instr_t ins);
    logic [15:0] s;
    logic [15:0] t;
    logic [15:0] pc1;
    logic [15:0] ea;
    logic [15:0] br;
    logic [15:0] nxt;
    s   = m_regs[ins.i.rs];
    t   = m_regs[ins.i.rt];
    pc1 = m_pc + 16'd1;
    ea  = s + sign_extend(ins.i.imm);
    br  = pc1 + sign_extend(ins.i.imm);
    nxt = pc1;
    exp_mem_access = 1'b0;
    exp_d_we       = 1'b0;
    exp_d_addr     = ea;
    exp_d_wdata    = t;
    exp_out_valid  = 1'b0;
    exp_out_data   = s;
    case (ins.i.opcode)
        OP_ADI: m_regs[ins.i.rt] = s + sign_extend(ins.i.imm);
        OP_ORI: m_regs[ins.i.rt] = s | {8'h00, ins.i.imm};
        OP_LHI: m_regs[ins.i.rt] = {ins.i.imm, 8'h00};
        OP_LWD: begin
            exp_mem_access   = 1'b1;
            m_regs[ins.i.rt] = m_dmem[ea[7:0]];
        end
        OP_SWD: begin
            exp_mem_access  = 1'b1;
            exp_d_we        = 1'b1;
            m_dmem[ea[7:0]] = t;
        end
        OP_BNE: if (s != t) nxt = br;
        OP_BEQ: if (s == t) nxt = br;
        OP_BGZ: if (!s[15] && s != 16'd0) nxt = br;
        OP_BLZ: if (s[15]) nxt = br;
        OP_JMP: nxt = {m_pc[15:12], ins.j.target};
        OP_JAL: begin
            nxt       = {m_pc[15:12], ins.j.target};
            m_regs[2] = pc1;
        end
        OP_RTYPE: begin
            case (ins.r.func)
                FN_ADD: m_regs[ins.r.rd] = s + t;
                FN_SUB: m_regs[ins.r.rd] = s - t;
                FN_AND: m_regs[ins.r.rd] = s & t;
                FN_ORR: m_regs[ins.r.rd] = s | t;
                FN_NOT: m_regs[ins.r.rd] = ~s;
                FN_TCP: m_regs[ins.r.rd] = -s;
                FN_SHL: m_regs[ins.r.rd] = s << 1;
                FN_SHR: m_regs[ins.r.rd] = s >> 1;
                FN_WWD: exp_out_valid = 1'b1;
                FN_JPR: nxt = s;
                FN_JRL: begin
                    nxt       = s;
                    m_regs[2] = pc1;
                end
                FN_HLT: m_halted = 1'b1;
                default: ;
            endcase
        end
        default: ;
    endcase
    m_pc = nxt;
endtask

`endif

// ==== verif/tb_cpu.sv ====
`timescale 1ns/1ps

module tb_cpu;
    import cpu_pkg::*;

    localparam logic [15:0] RESET_PC     = 16'h0008;
    localparam int          MEM_WORDS    = 256;
    localparam int          PROG_LEN     = 48;
    localparam int          RAND_SLOTS   = PROG_LEN - 5;
    localparam int          NUM_PROGRAMS = 50;
    localparam int          MAX_CYCLES   = 4 * PROG_LEN;
    localparam int          HOLD_CYCLES  = 20;

    logic        clk = 1'b0;
    logic        arst_n;
    logic [15:0] i_addr;
    logic [15:0] i_data;
    logic [15:0] d_addr;
    logic [15:0] d_wdata;
    logic [15:0] d_rdata;
    logic [15:0] out_data;
    logic        d_we;
    logic        out_valid;
    logic        halted;

    logic [15:0] imem [MEM_WORDS];
    logic [15:0] dmem [MEM_WORDS];
    bit          landable [PROG_LEN];
    string       test_name;

    `include "cpu_ref_model.svh"

    cpu_core #(.RESET_PC(RESET_PC)) dut (
        .clk       (clk),
        .arst_n    (arst_n),
        .i_data    (i_data),
        .i_addr    (i_addr),
        .d_addr    (d_addr),
        .d_wdata   (d_wdata),
        .d_we      (d_we),
        .d_rdata   (d_rdata),
        .out_valid (out_valid),
        .out_data  (out_data),
        .halted    (halted)
    );

    always #50 clk = ~clk;

    assign i_data  = imem[i_addr[7:0]];
    assign d_rdata = dmem[d_addr[7:0]];

    // ##########################################################
    // Checking
    // ##########################################################

    task automatic stop_with_failure(input string reason);
        $display("%s", reason);
        $display("** FAIL **");
        $fatal(1, "Simulation stopped");
    endtask

    task automatic check_value(input string what, input logic [15:0] expected,
                               input logic [15:0] actual);
        if (actual !== expected) begin
            stop_with_failure($sformatf("Mismatch %s %s: expected %h, actual %h",
                                        test_name, what, expected, actual));
        end
    endtask

    // ##########################################################
    // Program generation
    // ##########################################################

    function automatic logic [15:0] rtype_word(input func_e f, input logic [1:0] rs,
                                               input logic [1:0] rt, input logic [1:0] rd);
        instr_t w;
        w.r.opcode = OP_RTYPE;
        w.r.rs     = rs;
        w.r.rt     = rt;
        w.r.rd     = rd;
        w.r.func   = f;
        return w;
    endfunction

    function automatic logic [15:0] itype_word(input opcode_e op, input logic [1:0] rs,
                                               input logic [1:0] rt, input logic [7:0] imm);
        instr_t w;
        w.i.opcode = op;
        w.i.rs     = rs;
        w.i.rt     = rt;
        w.i.imm    = imm;
        return w;
    endfunction

    function automatic logic [15:0] jtype_word(input opcode_e op, input logic [11:0] target);
        instr_t w;
        w.j.opcode = op;
        w.j.target = target;
        return w;
    endfunction

    // Random slot at or after lo that control flow may enter
    function automatic int pick_target(input int lo);
        int count;
        int n;
        count = 0;
        for (int k = lo; k < PROG_LEN; k++) begin
            if (landable[k]) count++;
        end
        n = $urandom_range(0, count - 1);
        for (int k = lo; k < PROG_LEN; k++) begin
            if (landable[k]) begin
                if (n == 0) return k;
                n--;
            end
        end
        return PROG_LEN - 1;
    endfunction

    task automatic generate_program();
        opcode_e     imm_ops [3] = '{OP_ADI, OP_ORI, OP_LHI};
        opcode_e     mem_ops [2] = '{OP_LWD, OP_SWD};
        opcode_e     br_ops [4]  = '{OP_BNE, OP_BEQ, OP_BGZ, OP_BLZ};
        int          kind [PROG_LEN];
        int          s;
        int          tgt;
        int          base;
        logic [15:0] dest;
        logic [1:0]  x;
        for (int k = 0; k < MEM_WORDS; k++) begin
            imem[k] = rtype_word(FN_HLT, 2'd0, 2'd0, 2'd0);
            dmem[k] = 16'($urandom);
        end
        // A register jump needs LHI and ORI in front of it, so only its first slot is a target
        s = 0;
        while (s < RAND_SLOTS) begin
            kind[s]     = $urandom_range(0, 6);
            landable[s] = 1'b1;
            if (kind[s] == 6 && s + 3 <= RAND_SLOTS) begin
                kind[s + 1]     = -1;
                kind[s + 2]     = -1;
                landable[s + 1] = 1'b0;
                landable[s + 2] = 1'b0;
                s += 3;
            end else begin
                if (kind[s] == 6) kind[s] = 0;
                s++;
            end
        end
        for (int k = RAND_SLOTS; k < PROG_LEN; k++) begin
            landable[k] = 1'b1;
        end
        for (int k = 0; k < RAND_SLOTS; k++) begin
            base = int'(RESET_PC) + k;
            case (kind[k])
                0: imem[base] = rtype_word(func_e'(6'($urandom_range(0, 7))),
                                           2'($urandom), 2'($urandom), 2'($urandom));
                1: imem[base] = itype_word(imm_ops[$urandom_range(0, 2)],
                                           2'($urandom), 2'($urandom), 8'($urandom));
                2: imem[base] = itype_word(mem_ops[$urandom_range(0, 1)],
                                           2'($urandom), 2'($urandom), 8'($urandom));
                3: imem[base] = rtype_word(FN_WWD, 2'($urandom), 2'd0, 2'd0);
                4: begin
                    tgt         = pick_target(k + 1);
                    imem[base]  = itype_word(br_ops[$urandom_range(0, 3)],
                                             2'($urandom), 2'($urandom), 8'(tgt - k - 1));
                end
                5: begin
                    tgt        = pick_target(k + 1);
                    dest       = RESET_PC + 16'(tgt);
                    imem[base] = jtype_word($urandom_range(0, 1) ? OP_JAL : OP_JMP,
                                            dest[11:0]);
                end
                6: begin
                    tgt            = pick_target(k + 3);
                    dest           = RESET_PC + 16'(tgt);
                    x              = 2'($urandom);
                    imem[base]     = itype_word(OP_LHI, 2'd0, x, dest[15:8]);
                    imem[base + 1] = itype_word(OP_ORI, x, x, dest[7:0]);
                    imem[base + 2] = rtype_word($urandom_range(0, 1) ? FN_JRL : FN_JPR,
                                                x, 2'd0, 2'd0);
                end
                default: ;
            endcase
        end
        // Dump every register before the final HLT
        for (int r = 0; r < 4; r++) begin
            imem[int'(RESET_PC) + RAND_SLOTS + r] = rtype_word(FN_WWD, 2'(r), 2'd0, 2'd0);
        end
    endtask

    // ##########################################################
    // Lock-step run of one program
    // ##########################################################

    task automatic run_program(input int prog);
        bit          done;
        logic        st_we;
        logic [15:0] st_addr;
        logic [15:0] st_data;
        test_name = $sformatf("program %0d", prog);
        arst_n    = 1'b0;
        generate_program();
        reset_model();
        m_dmem = dmem;
        repeat (3) begin
            @(negedge clk);
            check_value("fetch address in reset", RESET_PC, i_addr);
            check_value("store strobe in reset", 16'd0, 16'(d_we));
            check_value("output strobe in reset", 16'd0, 16'(out_valid));
            check_value("halted in reset", 16'd0, 16'(halted));
        end
        arst_n = 1'b1;
        done   = 1'b0;
        for (int c = 0; c < MAX_CYCLES && !done; c++) begin
            @(negedge clk);
            check_value("fetch address", m_pc, i_addr);
            check_value("halted", 16'(m_halted), 16'(halted));
            if (m_halted) begin
                done = 1'b1;
            end else begin
                execute_instr(imem[m_pc[7:0]]);
                check_value("store strobe", 16'(exp_d_we), 16'(d_we));
                check_value("output strobe", 16'(exp_out_valid), 16'(out_valid));
                if (exp_mem_access) check_value("data address", exp_d_addr, d_addr);
                if (exp_d_we) check_value("store data", exp_d_wdata, d_wdata);
                if (exp_out_valid) check_value("output data", exp_out_data, out_data);
                st_we   = d_we;
                st_addr = d_addr;
                st_data = d_wdata;
                @(posedge clk);
                if (st_we) dmem[st_addr[7:0]] = st_data;
            end
        end
        if (!done) begin
            stop_with_failure($sformatf("The core did not halt within %0d cycles in %s",
                                        MAX_CYCLES, test_name));
        end
        repeat (HOLD_CYCLES) begin
            @(negedge clk);
            check_value("fetch address after halt", m_pc, i_addr);
            check_value("halted after halt", 16'd1, 16'(halted));
            check_value("store strobe after halt", 16'd0, 16'(d_we));
            check_value("output strobe after halt", 16'd0, 16'(out_valid));
        end
        for (int k = 0; k < MEM_WORDS; k++) begin
            check_value($sformatf("data memory word %0d", k), m_dmem[k], dmem[k]);
        end
    endtask

    initial begin
        arst_n = 1'b0;
        void'($urandom(28));
        for (int p = 0; p < NUM_PROGRAMS; p++) begin
            run_program(p);
        end
        $display("** PASS **");
        $finish;
    end

endmodule

// ==== files.f ====
+incdir+verif
design/cpu_pkg.sv
design/imm_extender.sv
design/control_decoder.sv
design/register_file.sv
design/alu.sv
design/cpu_core.sv
verif/tb_cpu.sv

// ==== Makefile ====
TOP := tb_cpu

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -j 0 -f files.f --top-module $(TOP) -Mdir obj_dir
	@out=$$(./obj_dir/V$(TOP)); echo "$$out"; echo "$$out" | grep -qF '** PASS **'

clean:
	rm -rf obj_dir
